//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_cfg_pkg::*, isa_pkg::*; (
    input  alu_type_e                 i_type,
    input  logic [DATA_WIDTH - 1 : 0] i_rs1_data,
    input  logic [DATA_WIDTH - 1 : 0] i_rs2_data,
    output logic [DATA_WIDTH - 1 : 0] o_res,
    output logic                      o_zero,
    output logic                      o_over,
    output logic                      o_nega
);

    logic [DATA_WIDTH - 1 : 0] w_sum;
    logic [DATA_WIDTH - 1 : 0] w_diff;
    logic [4 : 0]              w_shamt;
    logic                      w_lt;
    logic                      w_ltu;

    assign w_sum   = i_rs1_data + i_rs2_data;
    assign w_diff  = i_rs1_data - i_rs2_data;
    assign w_shamt = i_rs2_data[4 : 0];
    assign w_lt    = $signed(i_rs1_data) < $signed(i_rs2_data);
    assign w_ltu   = i_rs1_data < i_rs2_data;

    always_comb begin
        o_over = 1'b0;
        case (i_type)
            ALU_ADD: begin
                o_res  = w_sum;
                o_over = (i_rs1_data[DATA_WIDTH - 1] == i_rs2_data[DATA_WIDTH - 1]) &&
                         (w_sum[DATA_WIDTH - 1] != i_rs1_data[DATA_WIDTH - 1]);
            end
            ALU_SUB: begin
                o_res  = w_diff;
                o_over = (i_rs1_data[DATA_WIDTH - 1] != i_rs2_data[DATA_WIDTH - 1]) &&
                         (w_diff[DATA_WIDTH - 1] != i_rs1_data[DATA_WIDTH - 1]);
            end
            ALU_AND:  o_res = i_rs1_data & i_rs2_data;
            ALU_OR:   o_res = i_rs1_data | i_rs2_data;
            ALU_XOR:  o_res = i_rs1_data ^ i_rs2_data;
            ALU_SLL:  o_res = i_rs1_data << w_shamt;
            ALU_SRL:  o_res = i_rs1_data >> w_shamt;
            ALU_SRA:  o_res = $unsigned($signed(i_rs1_data) >>> w_shamt);
            ALU_SLT, ALU_LT:   o_res = DATA_WIDTH'(w_lt);
            ALU_SLTU, ALU_LTU: o_res = DATA_WIDTH'(w_ltu);
            ALU_EQ:   o_res = DATA_WIDTH'(i_rs1_data == i_rs2_data);
            ALU_NE:   o_res = DATA_WIDTH'(i_rs1_data != i_rs2_data);
            ALU_GE:   o_res = DATA_WIDTH'(!w_lt);
            ALU_GEU:  o_res = DATA_WIDTH'(!w_ltu);
            default:  o_res = i_rs2_data; // pass b for lui.
        endcase
    end

    assign o_zero = (o_res == {DATA_WIDTH{1'b0}});
    assign o_nega = o_res[DATA_WIDTH - 1];

endmodule

`default_nettype wire

//--- compile.f
cpu_cfg_pkg.sv
isa_pkg.sv
idu_exu_if.sv
ifu.sv
idu.sv
gpr.sv
alu.sv
exu.sv
cpu_top.sv
tb_clk_gen.sv
tb_cpu_assert.sv
tb_cpu.sv

//--- cpu_cfg_pkg.sv
`default_nettype none

package cpu_cfg_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int GPR_COUNT      = 2 ** REG_ADDR_WIDTH;

    // restart address after reset and after an environment call.
    localparam logic [ADDR_WIDTH - 1 : 0] RESET_PC = {ADDR_WIDTH{1'b0}};
    localparam logic [ADDR_WIDTH - 1 : 0] PC_STEP  = ADDR_WIDTH'(4); // one instruction word.

endpackage

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_cfg_pkg::*; (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_sys_ready,

    output logic [ADDR_WIDTH - 1 : 0]     o_ifu_pc,
    input  logic [DATA_WIDTH - 1 : 0]     i_ifu_inst,

    output logic                          o_alu_zero,
    output logic                          o_alu_over,
    output logic                          o_alu_nega,

    output logic                          o_wb_en,
    output logic [REG_ADDR_WIDTH - 1 : 0] o_wb_rd,
    output logic [DATA_WIDTH - 1 : 0]     o_wb_data
);

    logic                          w_exu_jmp_en;
    logic [ADDR_WIDTH - 1 : 0]     w_exu_jmp_pc;
    logic [REG_ADDR_WIDTH - 1 : 0] w_rs1_addr;
    logic [REG_ADDR_WIDTH - 1 : 0] w_rs2_addr;
    logic [DATA_WIDTH - 1 : 0]     w_rs1_data;
    logic [DATA_WIDTH - 1 : 0]     w_rs2_data;

    idu_exu_if idu_exu_bus ();

    ifu ifu_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sys_ready (i_sys_ready),
        .i_exu_jmp_en(w_exu_jmp_en),
        .i_exu_jmp_pc(w_exu_jmp_pc),
        .o_ifu_pc    (o_ifu_pc)
    );

    idu idu_inst (
        .i_ifu_inst(i_ifu_inst),
        .i_ifu_pc  (o_ifu_pc),
        .o_rs1_addr(w_rs1_addr),
        .o_rs2_addr(w_rs2_addr),
        .i_rs1_data(w_rs1_data),
        .i_rs2_data(w_rs2_data),
        .exu_bus   (idu_exu_bus.idu)
    );

    gpr gpr_inst (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs1_addr(w_rs1_addr),
        .i_rs2_addr(w_rs2_addr),
        .o_rs1_data(w_rs1_data),
        .o_rs2_data(w_rs2_data),
        .i_wb_en   (o_wb_en),
        .i_wb_rd   (o_wb_rd),
        .i_wb_data (o_wb_data)
    );

    exu exu_inst (
        .i_sys_ready (i_sys_ready),
        .i_ifu_pc    (o_ifu_pc),
        .exu_bus     (idu_exu_bus.exu),
        .o_alu_res   (),
        .o_alu_zero  (o_alu_zero),
        .o_alu_over  (o_alu_over),
        .o_alu_nega  (o_alu_nega),
        .o_exu_jmp_en(w_exu_jmp_en),
        .o_exu_jmp_pc(w_exu_jmp_pc),
        .o_wb_en     (o_wb_en),
        .o_wb_rd     (o_wb_rd),
        .o_wb_data   (o_wb_data)
    );

endmodule

`default_nettype wire

//--- exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu import cpu_cfg_pkg::*, isa_pkg::*; (
    input  logic                          i_sys_ready,
    input  logic [ADDR_WIDTH - 1 : 0]     i_ifu_pc,

    idu_exu_if.exu                        exu_bus,

    output logic [DATA_WIDTH - 1 : 0]     o_alu_res,
    output logic                          o_alu_zero,
    output logic                          o_alu_over,
    output logic                          o_alu_nega,

    output logic                          o_exu_jmp_en,
    output logic [ADDR_WIDTH - 1 : 0]     o_exu_jmp_pc,

    output logic                          o_wb_en,
    output logic [REG_ADDR_WIDTH - 1 : 0] o_wb_rd,
    output logic [DATA_WIDTH - 1 : 0]     o_wb_data
);

    logic [DATA_WIDTH - 1 : 0] w_alu_res;
    logic                      w_alu_zero;
    logic                      w_alu_over;
    logic                      w_alu_nega;
    logic                      w_jmp_en;

    alu alu_inst (
        .i_type    (exu_bus.alu_type),
        .i_rs1_data(exu_bus.alu_rs1_data),
        .i_rs2_data(exu_bus.alu_rs2_data),
        .o_res     (w_alu_res),
        .o_zero    (w_alu_zero),
        .o_over    (w_alu_over),
        .o_nega    (w_alu_nega)
    );

    assign o_alu_res  = i_sys_ready ? w_alu_res  : {DATA_WIDTH{1'b0}};
    assign o_alu_zero = i_sys_ready ? w_alu_zero : 1'b0;
    assign o_alu_over = i_sys_ready ? w_alu_over : 1'b0;
    assign o_alu_nega = i_sys_ready ? w_alu_nega : 1'b0;

    always_comb begin
        w_jmp_en     = 1'b0;
        o_exu_jmp_pc = {ADDR_WIDTH{1'b0}};
        case (exu_bus.jmp_type)
            JMP_J: begin
                w_jmp_en     = 1'b1;
                o_exu_jmp_pc = {o_alu_res[ADDR_WIDTH - 1 : 1], 1'b0}; // jalr target is halfword.
            end
            JMP_B: begin
                if (o_alu_res == DATA_WIDTH'(1)) begin
                    w_jmp_en     = 1'b1;
                    o_exu_jmp_pc = i_ifu_pc + exu_bus.jmp_or_gpr_data;
                end
            end
            JMP_E: begin
                w_jmp_en     = 1'b1;
                o_exu_jmp_pc = RESET_PC;
            end
            default: begin
            end
        endcase
    end

    assign o_exu_jmp_en = i_sys_ready && w_jmp_en;

    assign o_wb_en   = i_sys_ready && exu_bus.wb_en;
    assign o_wb_rd   = exu_bus.wb_rd;
    assign o_wb_data = !i_sys_ready             ? {DATA_WIDTH{1'b0}} :
                       (exu_bus.jmp_type == JMP_J) ? i_ifu_pc + PC_STEP : o_alu_res;

endmodule

`default_nettype wire

//--- gpr.sv
`timescale 1ns/1ps
`default_nettype none

module gpr import cpu_cfg_pkg::*; (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic [REG_ADDR_WIDTH - 1 : 0] i_rs1_addr,
    input  logic [REG_ADDR_WIDTH - 1 : 0] i_rs2_addr,
    output logic [DATA_WIDTH - 1 : 0]     o_rs1_data,
    output logic [DATA_WIDTH - 1 : 0]     o_rs2_data,

    input  logic                          i_wb_en,
    input  logic [REG_ADDR_WIDTH - 1 : 0] i_wb_rd,
    input  logic [DATA_WIDTH - 1 : 0]     i_wb_data
);

    logic [DATA_WIDTH - 1 : 0] r_regs [GPR_COUNT];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < GPR_COUNT; i++) begin
                r_regs[i] <= {DATA_WIDTH{1'b0}};
            end
        end
        else if (i_wb_en && i_wb_rd != '0) begin // x0 drops every write.
            r_regs[i_wb_rd] <= i_wb_data;
        end
    end

    assign o_rs1_data = (i_rs1_addr == '0) ? {DATA_WIDTH{1'b0}} : r_regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? {DATA_WIDTH{1'b0}} : r_regs[i_rs2_addr];

endmodule

`default_nettype wire

//--- idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu import cpu_cfg_pkg::*, isa_pkg::*; (
    input  inst_u                         i_ifu_inst,
    input  logic [ADDR_WIDTH - 1 : 0]     i_ifu_pc,

    output logic [REG_ADDR_WIDTH - 1 : 0] o_rs1_addr,
    output logic [REG_ADDR_WIDTH - 1 : 0] o_rs2_addr,
    input  logic [DATA_WIDTH - 1 : 0]     i_rs1_data,
    input  logic [DATA_WIDTH - 1 : 0]     i_rs2_data,

    idu_exu_if.idu                        exu_bus
);

    logic [DATA_WIDTH - 1 : 0] w_imm_i;
    logic [DATA_WIDTH - 1 : 0] w_imm_u;
    logic [DATA_WIDTH - 1 : 0] w_imm_b;
    logic [DATA_WIDTH - 1 : 0] w_imm_j;

    function automatic alu_type_e f_alu_op(input logic [2 : 0] funct3, input logic alt,
                                           input logic is_reg);
        case (funct3)
            F3_ADD:  return (is_reg && alt) ? ALU_SUB : ALU_ADD; // addi has no sub form.
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign o_rs1_addr = i_ifu_inst.r.rs1;
    assign o_rs2_addr = i_ifu_inst.r.rs2;

    assign w_imm_i = {{20{i_ifu_inst.i.imm12[11]}}, i_ifu_inst.i.imm12};
    assign w_imm_u = {i_ifu_inst.i.imm12, i_ifu_inst.i.rs1, i_ifu_inst.i.funct3, 12'h0};
    assign w_imm_b = {{19{i_ifu_inst.i.imm12[11]}}, i_ifu_inst.i.imm12[11],
                      i_ifu_inst.i.rd[0], i_ifu_inst.i.imm12[10 : 5],
                      i_ifu_inst.i.rd[4 : 1], 1'b0};
    assign w_imm_j = {{11{i_ifu_inst.i.imm12[11]}}, i_ifu_inst.i.imm12[11],
                      i_ifu_inst.i.rs1, i_ifu_inst.i.funct3, i_ifu_inst.i.imm12[0],
                      i_ifu_inst.i.imm12[10 : 1], 1'b0};

    always_comb begin
        exu_bus.alu_type        = ALU_ADD;
        exu_bus.alu_rs1_data    = {DATA_WIDTH{1'b0}};
        exu_bus.alu_rs2_data    = {DATA_WIDTH{1'b0}};
        exu_bus.jmp_type        = JMP_NONE;
        exu_bus.jmp_or_gpr_data = {DATA_WIDTH{1'b0}};
        exu_bus.wb_en           = 1'b0;
        exu_bus.wb_rd           = i_ifu_inst.r.rd;

        case (i_ifu_inst.r.opcode)
            OP_REG: begin
                exu_bus.alu_type     = f_alu_op(i_ifu_inst.r.funct3, i_ifu_inst.r.funct7[5], 1'b1);
                exu_bus.alu_rs1_data = i_rs1_data;
                exu_bus.alu_rs2_data = i_rs2_data;
                exu_bus.wb_en        = 1'b1;
            end
            OP_IMM: begin
                exu_bus.alu_type     = f_alu_op(i_ifu_inst.r.funct3, i_ifu_inst.r.funct7[5], 1'b0);
                exu_bus.alu_rs1_data = i_rs1_data;
                exu_bus.alu_rs2_data = w_imm_i;
                exu_bus.wb_en        = 1'b1;
            end
            OP_LUI: begin
                exu_bus.alu_type     = ALU_PASS_B;
                exu_bus.alu_rs2_data = w_imm_u;
                exu_bus.wb_en        = 1'b1;
            end
            OP_AUIPC: begin
                exu_bus.alu_rs1_data = i_ifu_pc;
                exu_bus.alu_rs2_data = w_imm_u;
                exu_bus.wb_en        = 1'b1;
            end
            OP_JAL: begin
                exu_bus.alu_rs1_data = i_ifu_pc;
                exu_bus.alu_rs2_data = w_imm_j;
                exu_bus.jmp_type     = JMP_J;
                exu_bus.wb_en        = 1'b1;
            end
            OP_JALR: begin
                exu_bus.alu_rs1_data = i_rs1_data;
                exu_bus.alu_rs2_data = w_imm_i;
                exu_bus.jmp_type     = JMP_J;
                exu_bus.wb_en        = 1'b1;
            end
            OP_BRANCH: begin
                exu_bus.alu_rs1_data    = i_rs1_data;
                exu_bus.alu_rs2_data    = i_rs2_data;
                exu_bus.jmp_or_gpr_data = w_imm_b;
                exu_bus.jmp_type        = JMP_B;
                case (i_ifu_inst.r.funct3)
                    F3_BEQ:  exu_bus.alu_type = ALU_EQ;
                    F3_BNE:  exu_bus.alu_type = ALU_NE;
                    F3_BLT:  exu_bus.alu_type = ALU_LT;
                    F3_BGE:  exu_bus.alu_type = ALU_GE;
                    F3_BLTU: exu_bus.alu_type = ALU_LTU;
                    F3_BGEU: exu_bus.alu_type = ALU_GEU;
                    default: exu_bus.jmp_type = JMP_NONE; // reserved funct3 acts as a nop.
                endcase
            end
            OP_SYSTEM: begin
                if (i_ifu_inst.i.funct3 == F3_PRIV && i_ifu_inst.i.imm12 == F12_ECALL) begin
                    exu_bus.jmp_type = JMP_E;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- idu_exu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface idu_exu_if import cpu_cfg_pkg::*, isa_pkg::*; ();

    alu_type_e                     alu_type;
    logic [DATA_WIDTH - 1 : 0]     alu_rs1_data;
    logic [DATA_WIDTH - 1 : 0]     alu_rs2_data;
    jmp_type_e                     jmp_type;
    logic [DATA_WIDTH - 1 : 0]     jmp_or_gpr_data; // branch offset.
    logic                          wb_en;
    logic [REG_ADDR_WIDTH - 1 : 0] wb_rd;

    modport idu (
        output alu_type, alu_rs1_data, alu_rs2_data,
        output jmp_type, jmp_or_gpr_data, wb_en, wb_rd
    );

    modport exu (
        input alu_type, alu_rs1_data, alu_rs2_data,
        input jmp_type, jmp_or_gpr_data, wb_en, wb_rd
    );

endinterface

`default_nettype wire

//--- ifu.sv
`timescale 1ns/1ps
`default_nettype none

module ifu import cpu_cfg_pkg::*; (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_sys_ready,

    input  logic                      i_exu_jmp_en,
    input  logic [ADDR_WIDTH - 1 : 0] i_exu_jmp_pc,
    output logic [ADDR_WIDTH - 1 : 0] o_ifu_pc
);

    logic [ADDR_WIDTH - 1 : 0] r_pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_pc <= RESET_PC;
        end
        else if (i_sys_ready) begin
            if (i_exu_jmp_en) begin
                r_pc <= i_exu_jmp_pc;
            end
            else begin
                r_pc <= r_pc + PC_STEP;
            end
        end
    end

    assign o_ifu_pc = r_pc;

endmodule

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam logic [6 : 0] OP_REG    = 7'b0110011;
    localparam logic [6 : 0] OP_IMM    = 7'b0010011;
    localparam logic [6 : 0] OP_LUI    = 7'b0110111;
    localparam logic [6 : 0] OP_AUIPC  = 7'b0010111;
    localparam logic [6 : 0] OP_BRANCH = 7'b1100011;
    localparam logic [6 : 0] OP_JAL    = 7'b1101111;
    localparam logic [6 : 0] OP_JALR   = 7'b1100111;
    localparam logic [6 : 0] OP_SYSTEM = 7'b1110011;

    localparam logic [2 : 0] F3_ADD  = 3'b000;
    localparam logic [2 : 0] F3_SLL  = 3'b001;
    localparam logic [2 : 0] F3_SLT  = 3'b010;
    localparam logic [2 : 0] F3_SLTU = 3'b011;
    localparam logic [2 : 0] F3_XOR  = 3'b100;
    localparam logic [2 : 0] F3_SR   = 3'b101; // srl or sra, picked by funct7.
    localparam logic [2 : 0] F3_OR   = 3'b110;
    localparam logic [2 : 0] F3_AND  = 3'b111;

    localparam logic [2 : 0] F3_BEQ  = 3'b000;
    localparam logic [2 : 0] F3_BNE  = 3'b001;
    localparam logic [2 : 0] F3_BLT  = 3'b100;
    localparam logic [2 : 0] F3_BGE  = 3'b101;
    localparam logic [2 : 0] F3_BLTU = 3'b110;
    localparam logic [2 : 0] F3_BGEU = 3'b111;

    localparam logic [2 : 0]  F3_PRIV   = 3'b000;
    localparam logic [11 : 0] F12_ECALL = 12'h000;

    typedef enum logic [4 : 0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
        ALU_PASS_B
    } alu_type_e;

    typedef enum logic [1 : 0] {
        JMP_NONE, JMP_J, JMP_B, JMP_E
    } jmp_type_e;

    typedef struct packed {
        logic [6 : 0] funct7;
        logic [4 : 0] rs2;
        logic [4 : 0] rs1;
        logic [2 : 0] funct3;
        logic [4 : 0] rd;
        logic [6 : 0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11 : 0] imm12;
        logic [4 : 0]  rs1;
        logic [2 : 0]  funct3;
        logic [4 : 0]  rd;
        logic [6 : 0]  opcode;
    } inst_i_t;

    // the same word, seen as register fields or as immediate fields.
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);

    localparam time HALF_PERIOD = 4ns; // 8 ns clock period.

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import isa_pkg::*; ();

    localparam logic [31:0] NOP   = 32'h00000013;
    localparam logic [31:0] ECALL = 32'h00000073;

    wire         clk;
    logic        rst;
    logic        ready;
    wire  [31:0] pc;
    wire  [31:0] inst;
    wire         alu_zero;
    wire         alu_over;
    wire         alu_nega;
    wire         wb_en;
    wire  [4:0]  wb_rd;
    wire  [31:0] wb_data;

    logic [31:0] imem [64];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] lfsr_state;
    int          prog_len;

    tb_clk_gen clk_gen_inst (.o_clk(clk));

    cpu_top cpu_top_inst (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_sys_ready(ready),
        .o_ifu_pc   (pc),
        .i_ifu_inst (inst),
        .o_alu_zero (alu_zero),
        .o_alu_over (alu_over),
        .o_alu_nega (alu_nega),
        .o_wb_en    (wb_en),
        .o_wb_rd    (wb_rd),
        .o_wb_data  (wb_data)
    );

    assign inst = (pc < 32'd256) ? imem[pc[7:2]] : NOP; // words outside the array read as nop.

    task automatic fail_run();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = 32'd0;
        for (int k = 0; k < nbits; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic sub,
                                             input logic arith, input logic [31:0] a,
                                             input logic [31:0] b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return arith ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic new_program();
        for (int k = 0; k < 64; k++) begin
            imem[k] = NOP;
        end
        prog_len = 0;
    endtask

    // lui rounds up when the low half sign-extends negative.
    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        emit(enc_u(v[31:12] + {19'd0, v[11]}, rd, OP_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, OP_IMM));
    endtask

    task automatic reset_dut();
        int cnt;
        @(posedge clk);
        #1;
        rst   = 1'b1;
        ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        cnt = 0;
        while (pc !== 32'd0) begin
            if (cnt >= 8) begin
                $display("timeout waiting for the pc to reach the reset address");
                fail_run();
            end
            @(posedge clk);
            #1;
            cnt++;
        end
        rst = 1'b0;
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = 32'd0;
        end
        m_pc = 32'd0;
    endtask

    // reference model of one instruction, checked against the commit port.
    task automatic model_step(input logic [31:0] in);
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] data;
        logic [31:0] npc;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        en;
        logic        chk;
        logic        over;
        logic        sub;
        op    = in[6:0];
        f3    = in[14:12];
        rd    = in[11:7];
        a     = m_regs[in[19:15]];
        imm_i = {{20{in[31]}}, in[31:20]};
        imm_u = {in[31:12], 12'd0};
        imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        en    = 1'b0;
        chk   = 1'b0;
        over  = 1'b0;
        res   = 32'd0;
        data  = 32'd0;
        npc   = m_pc + 32'd4;
        case (op)
            OP_REG, OP_IMM: begin
                b   = (op == OP_REG) ? m_regs[in[24:20]] : imm_i;
                sub = (op == OP_REG) && in[30];
                res = alu_calc(f3, sub, in[30], a, b);
                if (f3 == 3'd0) begin
                    over = sub ? (a[31] != b[31]) && (res[31] != a[31])
                               : (a[31] == b[31]) && (res[31] != a[31]);
                end
                en   = 1'b1;
                chk  = 1'b1;
                data = res;
            end
            OP_LUI: begin
                en   = 1'b1;
                data = imm_u;
            end
            OP_AUIPC: begin
                en   = 1'b1;
                data = m_pc + imm_u;
            end
            OP_JAL: begin
                en   = 1'b1;
                data = m_pc + 32'd4;
                npc  = (m_pc + imm_j) & ~32'd1;
            end
            OP_JALR: begin
                en   = 1'b1;
                data = m_pc + 32'd4;
                npc  = (a + imm_i) & ~32'd1;
            end
            OP_BRANCH: begin
                b = m_regs[in[24:20]];
                case (f3)
                    3'd0: res = {31'd0, a == b};
                    3'd1: res = {31'd0, a != b};
                    3'd4: res = {31'd0, $signed(a) < $signed(b)};
                    3'd5: res = {31'd0, $signed(a) >= $signed(b)};
                    3'd6: res = {31'd0, a < b};
                    3'd7: res = {31'd0, a >= b};
                    default: res = 32'd0;
                endcase
                chk = (f3 != 3'd2) && (f3 != 3'd3);
                if (chk && res[0]) begin
                    npc = m_pc + imm_b;
                end
            end
            OP_SYSTEM: begin
                if (f3 == 3'd0 && in[31:20] == 12'd0) begin
                    npc = 32'd0;
                end
            end
            default: begin
            end
        endcase
        check_val("o_wb_en", {31'd0, wb_en}, {31'd0, en});
        if (en) begin
            check_val("o_wb_rd", {27'd0, wb_rd}, {27'd0, rd});
            check_val("o_wb_data", wb_data, data);
        end
        if (chk) begin
            check_val("o_alu_zero", {31'd0, alu_zero}, {31'd0, res == 32'd0});
            check_val("o_alu_nega", {31'd0, alu_nega}, {31'd0, res[31]});
            check_val("o_alu_over", {31'd0, alu_over}, {31'd0, over});
        end
        if (en && rd != 5'd0) begin
            m_regs[rd] = data;
        end
        m_pc = npc;
    endtask

    // one iteration per clock cycle; ready drops for stall_len cycles from stall_at.
    task automatic run_program(input int steps, input int stall_at, input int stall_len);
        reset_dut();
        for (int k = 0; k < steps; k++) begin
            ready = !(k >= stall_at && k < stall_at + stall_len);
            #2;
            check_val("o_ifu_pc", pc, m_pc);
            if (ready) begin
                model_step(inst);
            end
            else begin
                check_val("o_wb_en", {31'd0, wb_en}, 32'd0);
                check_val("flags", {29'd0, alu_zero, alu_over, alu_nega}, 32'd0);
            end
            @(posedge clk);
            #1;
        end
        ready = 1'b1;
    endtask

    task automatic build_alu_program(input logic [31:0] x, input logic [31:0] y);
        new_program();
        load_const(5'd1, x);
        load_const(5'd2, y);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));
        for (int f = 1; f < 8; f++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(f + 4)));
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                emit(enc_i({7'h00, 5'(rand_bits(5))}, 5'd1, 3'(f), 5'(f + 13), OP_IMM));
            end
            else begin
                emit(enc_i(12'(rand_bits(12)), 5'd1, 3'(f), 5'(f + 13), OP_IMM));
            end
        end
        emit(enc_i({7'h20, 5'(rand_bits(5))}, 5'd1, 3'd5, 5'd21, OP_IMM));
    endtask

    task automatic test_alu_ops();
        for (int round = 0; round < 4; round++) begin
            build_alu_program(rand_bits(32), rand_bits(32));
            run_program(prog_len + 2, 1000, 0);
        end
        // signed overflow on add, then on sub.
        build_alu_program(32'h7fffffff, 32'h7ffffff0);
        run_program(prog_len + 2, 1000, 0);
        build_alu_program(32'h80000000, 32'h7fffffff);
        run_program(prog_len + 2, 1000, 0);
    endtask

    task automatic test_upper_imm();
        new_program();
        emit(enc_u(20'(rand_bits(20)), 5'd1, OP_LUI));
        emit(enc_u(20'(rand_bits(20)), 5'd2, OP_AUIPC));
        emit(enc_u(20'(rand_bits(20)), 5'd3, OP_AUIPC));
        run_program(prog_len + 1, 1000, 0);
    endtask

    task automatic test_branches();
        logic [31:0] v;
        logic [31:0] w;
        for (int f = 0; f < 8; f++) begin
            for (int same = 0; same < 2; same++) begin
                if (f == 2 || f == 3) continue;
                // both positive, so w above v holds signed and unsigned.
                v = {2'b00, 30'(rand_bits(30))};
                w = same ? v : v + 32'd1 + {3'b000, 29'(rand_bits(29))};
                new_program();
                load_const(5'd1, v);
                load_const(5'd2, w);
                emit(enc_b(13'd8, 5'd2, 5'd1, 3'(f)));
                emit(enc_i(12'd5, 5'd0, 3'd0, 5'd5, OP_IMM));
                emit(enc_i(12'd6, 5'd0, 3'd0, 5'd6, OP_IMM));
                run_program(prog_len, 1000, 0);
            end
        end
    endtask

    task automatic test_jumps();
        new_program();
        emit(enc_j(21'd12, 5'd1));
        emit(NOP);
        emit(NOP);
        emit(enc_i(12'd33, 5'd0, 3'd0, 5'd7, OP_IMM));
        emit(enc_i(12'd0, 5'd7, 3'd0, 5'd2, OP_JALR)); // odd target loses bit 0.
        run_program(6, 1000, 0);
    endtask

    task automatic test_stall();
        build_alu_program(rand_bits(32), rand_bits(32));
        run_program(prog_len + 6, 5, 4);
    endtask

    task automatic test_ecall_x0();
        new_program();
        emit(enc_i(12'd1, 5'd1, 3'd0, 5'd1, OP_IMM));
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd0, OP_IMM));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd3));
        emit(ECALL);
        run_program(12, 1000, 0);
    endtask

    initial begin
        rst        = 1'b1;
        ready      = 1'b1;
        lfsr_state = 32'h5bed9a53;
        new_program();
        test_alu_ops();
        test_upper_imm();
        test_branches();
        test_jumps();
        test_stall();
        test_ecall_x0();
        $display("sim passed");
        $finish;
    end

    initial begin
        #1ms;
        $display("timeout, the run did not finish");
        fail_run();
    end

endmodule

`default_nettype wire

//--- tb_cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_assert (
    input wire        i_clk,
    input wire        i_rst,
    input wire        i_sys_ready,
    input wire        i_wb_en,
    input wire [4:0]  i_wb_rd,
    input wire [31:0] i_ifu_pc,
    input wire [31:0] i_x0_value
);

    no_commit_when_stalled: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_sys_ready |-> !i_wb_en)
        else $error("register write while the core is stalled");

    x0_never_written: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wb_en && i_wb_rd == 5'd0) |=> (i_x0_value == 32'd0))
        else $error("a write to x0 changed the stored register value");

    pc_word_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_ifu_pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    pc_holds_in_stall: assert property (@(posedge i_clk) disable iff (i_rst)
        !i_sys_ready |=> $stable(i_ifu_pc))
        else $error("pc moved during a stalled cycle");

endmodule

bind cpu_top tb_cpu_assert cpu_assert_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_sys_ready(i_sys_ready),
    .i_wb_en    (o_wb_en),
    .i_wb_rd    (o_wb_rd),
    .i_ifu_pc   (o_ifu_pc),
    .i_x0_value (gpr_inst.r_regs[0])
);

`default_nettype wire
